//--- include/array_params.svh
`ifndef ARRAY_PARAMS_SVH
`define ARRAY_PARAMS_SVH

// grid size
`define ARRAY_ROWS 4
`define ARRAY_COLS 4

// operand widths, signed
`define FEAT_WIDTH 8
`define WGHT_WIDTH 8

// full product plus two guard bits for a four row column sum
`define PSUM_WIDTH (`FEAT_WIDTH + `WGHT_WIDTH + 2)

// one 8-bit field per column or per row
`define CMD_WIDTH (`ARRAY_COLS * `WGHT_WIDTH)

`endif

//--- source/array_pkg.sv
`include "array_params.svh"

package array_pkg;

        // command opcodes
        typedef enum logic {
                OP_LOAD_ROW = 1'b0,
                OP_COMPUTE  = 1'b1
        } op_e;

        // command handshake states
        typedef enum logic {
                CMD_IDLE = 1'b0,
                CMD_ACK  = 1'b1
        } ctrl_state_e;

        // element data types
        typedef logic signed [`FEAT_WIDTH-1:0] feat_t;
        typedef logic signed [`WGHT_WIDTH-1:0] wght_t;
        typedef logic signed [`PSUM_WIDTH-1:0] psum_t;

endpackage

//--- source/array_dp_if.sv
`include "array_params.svh"

interface array_dp_if;

        // whole pipeline advances when high
        logic                               step;
        // shift a new weight row in at the top
        logic                               load_row;
        // command data held since the last accept
        logic [`CMD_WIDTH-1:0]              cmd_data;
        // latch bottom sums into the result register
        logic                               capture;
        // result register, column 0 in the low bits
        logic [`ARRAY_COLS*`PSUM_WIDTH-1:0] result;

        modport ctrl (
                output step,
                output load_row,
                output cmd_data,
                output capture,
                input  result
        );

        modport dp (
                input  step,
                input  load_row,
                input  cmd_data,
                input  capture,
                output result
        );

endinterface

//--- source/processing_element.sv
module processing_element
        import array_pkg::*;
(
        input  logic  clk_i,
        input  logic  rst_n_i,
        input  logic  step_i,
        input  logic  load_row_i,
        input  wght_t wght_i,
        input  feat_t feat_i,
        input  psum_t psum_i,
        output wght_t wght_o,
        output psum_t psum_o
);

        wght_t wght_q;
        psum_t psum_q;
        logic signed [$bits(feat_t)+$bits(wght_t)-1:0] prod;

        // stationary weight, passed down on each row load
        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        wght_q <= '0;
                end else if (load_row_i) begin
                        wght_q <= wght_i;
                end
        end

        // full width signed product
        assign prod = feat_i * wght_q;

        // column accumulation, one register per cell
        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        psum_q <= '0;
                end else if (step_i) begin
                        psum_q <= psum_i + psum_t'(prod);
                end
        end

        assign wght_o = wght_q;
        assign psum_o = psum_q;

endmodule

//--- source/pe_grid.sv
`include "array_params.svh"

module pe_grid
        import array_pkg::*;
(
        input  logic  clk_i,
        input  logic  rst_n_i,
        array_dp_if.dp dp
);

        feat_t row_feat [`ARRAY_ROWS];
        wght_t wght_w   [`ARRAY_ROWS][`ARRAY_COLS];
        psum_t psum_w   [`ARRAY_ROWS][`ARRAY_COLS];
        logic [`ARRAY_COLS*`PSUM_WIDTH-1:0] bottom;
        logic [`ARRAY_COLS*`PSUM_WIDTH-1:0] result_q;

        //////////////////////////////////////////////////////////////////////
        // feature skew, row r sees its field r steps late
        //////////////////////////////////////////////////////////////////////

        for (genvar r = 0; r < `ARRAY_ROWS; r++) begin : g_skew
                if (r == 0) begin : g_direct
                        assign row_feat[r] = feat_t'(dp.cmd_data[0 +: `FEAT_WIDTH]);
                end else begin : g_delay
                        feat_t dly_q [r];

                        always_ff @(posedge clk_i or negedge rst_n_i) begin
                                if (!rst_n_i) begin
                                        for (int k = 0; k < r; k++) begin
                                                dly_q[k] <= '0;
                                        end
                                end else if (dp.step) begin
                                        dly_q[0] <= feat_t'(dp.cmd_data[r*`FEAT_WIDTH +: `FEAT_WIDTH]);
                                        for (int k = 1; k < r; k++) begin
                                                dly_q[k] <= dly_q[k-1];
                                        end
                                end
                        end

                        assign row_feat[r] = dly_q[r-1];
                end
        end

        //////////////////////////////////////////////////////////////////////
        // element grid
        //////////////////////////////////////////////////////////////////////

        for (genvar r = 0; r < `ARRAY_ROWS; r++) begin : g_row
                for (genvar c = 0; c < `ARRAY_COLS; c++) begin : g_col
                        wght_t wght_in;
                        psum_t psum_in;

                        // top row takes the new weight row and a zero sum
                        if (r == 0) begin : g_top
                                assign wght_in = wght_t'(dp.cmd_data[c*`WGHT_WIDTH +: `WGHT_WIDTH]);
                                assign psum_in = '0;
                        end else begin : g_inner
                                assign wght_in = wght_w[r-1][c];
                                assign psum_in = psum_w[r-1][c];
                        end

                        processing_element u_pe (
                                .clk_i      (clk_i),
                                .rst_n_i    (rst_n_i),
                                .step_i     (dp.step),
                                .load_row_i (dp.load_row),
                                .wght_i     (wght_in),
                                .feat_i     (row_feat[r]),
                                .psum_i     (psum_in),
                                .wght_o     (wght_w[r][c]),
                                .psum_o     (psum_w[r][c])
                        );
                end
        end

        // pack the bottom row, column 0 lowest
        for (genvar c = 0; c < `ARRAY_COLS; c++) begin : g_bottom
                assign bottom[c*`PSUM_WIDTH +: `PSUM_WIDTH] = psum_w[`ARRAY_ROWS-1][c];
        end

        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        result_q <= '0;
                end else if (dp.capture) begin
                        result_q <= bottom;
                end
        end

        assign dp.result = result_q;

        // bottom sums move on the same edge, so a capture must also step
        a_capture_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                dp.capture |-> dp.step)
                else $error("capture while the array is stalled");

endmodule

//--- source/array_ctrl.sv
`include "array_params.svh"

module array_ctrl
        import array_pkg::*;
(
        input  logic                               clk_i,
        input  logic                               rst_n_i,
        input  logic                               cmd_req_i,
        input  op_e                                cmd_op_i,
        input  logic [`CMD_WIDTH-1:0]              cmd_data_i,
        output logic                               cmd_ack_o,
        output logic                               res_req_o,
        input  logic                               res_ack_i,
        output logic [`ARRAY_COLS*`PSUM_WIDTH-1:0] res_data_o,
        array_dp_if.ctrl                           dp
);

        ctrl_state_e             state_q;
        ctrl_state_e             state_d;
        logic                    accept_load;
        logic                    accept_comp;
        logic                    step;
        logic                    capture;
        logic                    load_row_q;
        logic                    res_full_q;
        logic [`CMD_WIDTH-1:0]   cmd_data_q;
        // one valid bit per pipeline stage, top bit means bottom sums ready
        logic [`ARRAY_ROWS:0]    tok_q;

        //////////////////////////////////////////////////////////////////////
        // stall and accept decisions
        //////////////////////////////////////////////////////////////////////

        // hold while a finished token cannot get into the result register
        assign step    = ~(tok_q[`ARRAY_ROWS] & (res_full_q | res_ack_i));
        assign capture = tok_q[`ARRAY_ROWS] & ~res_full_q & ~res_ack_i;

        // weights only change with an empty pipe
        assign accept_load = (state_q == CMD_IDLE) && cmd_req_i &&
                             (cmd_op_i == OP_LOAD_ROW) && (tok_q == '0);
        // new token enters stage 0 on a stepped edge only
        assign accept_comp = (state_q == CMD_IDLE) && cmd_req_i &&
                             (cmd_op_i == OP_COMPUTE) && step;

        //////////////////////////////////////////////////////////////////////
        // command handshake
        //////////////////////////////////////////////////////////////////////

        always_comb begin
                state_d = state_q;
                unique case (state_q)
                        CMD_IDLE: begin
                                if (accept_load || accept_comp) begin
                                        state_d = CMD_ACK;
                                end
                        end
                        CMD_ACK: begin
                                // wait for the host to drop req
                                if (!cmd_req_i) begin
                                        state_d = CMD_IDLE;
                                end
                        end
                endcase
        end

        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        state_q    <= CMD_IDLE;
                        load_row_q <= 1'b0;
                        cmd_data_q <= '0;
                end else begin
                        state_q    <= state_d;
                        load_row_q <= accept_load;
                        if (accept_load || accept_comp) begin
                                cmd_data_q <= cmd_data_i;
                        end
                end
        end

        // token shift, frozen together with the grid
        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        tok_q <= '0;
                end else if (step) begin
                        tok_q <= {tok_q[`ARRAY_ROWS-1:0], accept_comp};
                end
        end

        //////////////////////////////////////////////////////////////////////
        // result handshake
        //////////////////////////////////////////////////////////////////////

        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        res_full_q <= 1'b0;
                end else if (capture) begin
                        res_full_q <= 1'b1;
                end else if (res_full_q && res_ack_i) begin
                        res_full_q <= 1'b0;
                end
        end

        assign cmd_ack_o   = (state_q == CMD_ACK);
        assign res_req_o   = res_full_q;
        assign res_data_o  = dp.result;

        assign dp.step     = step;
        assign dp.load_row = load_row_q;
        assign dp.cmd_data = cmd_data_q;
        assign dp.capture  = capture;

        // ack only ever answers a pending request
        a_ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                $rose(cmd_ack_o) |-> $past(cmd_req_i))
                else $error("cmd_ack_o rose without cmd_req_i");

        a_load_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                dp.load_row |-> (tok_q == '0))
                else $error("weight row load with tokens in flight");

        // grid result register must hold while the host samples it
        a_res_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                res_req_o && $past(res_req_o) |-> res_data_o == $past(res_data_o))
                else $error("res_data_o changed during res_req_o");

endmodule

//--- source/systolic_array_top.sv
`include "array_params.svh"

module systolic_array_top
        import array_pkg::*;
(
        input  logic                               clk_i,
        input  logic                               rst_n_i,

        // command channel, four phase req/ack
        input  logic                               cmd_req_i,
        input  op_e                                cmd_op_i,
        input  logic [`CMD_WIDTH-1:0]              cmd_data_i,
        output logic                               cmd_ack_o,

        // result channel, four phase req/ack
        output logic                               res_req_o,
        input  logic                               res_ack_i,
        output logic [`ARRAY_COLS*`PSUM_WIDTH-1:0] res_data_o
);

        //////////////////////////////////////////////////////////////////////
        // controller to datapath link
        //////////////////////////////////////////////////////////////////////

        array_dp_if dp_if ();

        //////////////////////////////////////////////////////////////////////
        // handshake and pipeline control
        //////////////////////////////////////////////////////////////////////

        array_ctrl u_ctrl (
                .clk_i      (clk_i),
                .rst_n_i    (rst_n_i),
                .cmd_req_i  (cmd_req_i),
                .cmd_op_i   (cmd_op_i),
                .cmd_data_i (cmd_data_i),
                .cmd_ack_o  (cmd_ack_o),
                .res_req_o  (res_req_o),
                .res_ack_i  (res_ack_i),
                .res_data_o (res_data_o),
                .dp         (dp_if)
        );

        //////////////////////////////////////////////////////////////////////
        // 4x4 weight stationary grid
        //////////////////////////////////////////////////////////////////////

        pe_grid u_grid (
                .clk_i   (clk_i),
                .rst_n_i (rst_n_i),
                .dp      (dp_if)
        );

endmodule

//--- verif/systolic_array_tb.sv
`include "array_params.svh"

module systolic_array_tb
        import array_pkg::*;
();

        timeunit 1ns;
        timeprecision 100ps;

        localparam int PW  = `PSUM_WIDTH;
        localparam int RW  = `ARRAY_COLS * `PSUM_WIDTH;
        localparam int TMO = 200;

        typedef struct {
                int                    test;
                op_e                   op;
                logic [`CMD_WIDTH-1:0] data;
                logic [RW-1:0]         exp_res;
                int                    ack_dly;
        } vec_t;

        logic                  clk_i;
        logic                  rst_n_i;
        logic                  cmd_req_i;
        op_e                   cmd_op_i;
        logic [`CMD_WIDTH-1:0] cmd_data_i;
        logic                  cmd_ack_o;
        logic                  res_req_o;
        logic                  res_ack_i;
        logic [RW-1:0]         res_data_o;

        vec_t          vec_tbl [$];
        logic [RW-1:0] exp_q [$];
        int            dly_q [$];
        int            wmodel [`ARRAY_ROWS][`ARRAY_COLS];
        string         test_name [1:6];
        int            errors;
        int            checks;
        int            results;
        integer        seed;
        bit            rst_done;
        bit            collecting;

        systolic_array_top u_dut (
                .clk_i      (clk_i),
                .rst_n_i    (rst_n_i),
                .cmd_req_i  (cmd_req_i),
                .cmd_op_i   (cmd_op_i),
                .cmd_data_i (cmd_data_i),
                .cmd_ack_o  (cmd_ack_o),
                .res_req_o  (res_req_o),
                .res_ack_i  (res_ack_i),
                .res_data_o (res_data_o)
        );

        initial begin
                clk_i = 1'b0;
                forever #4 clk_i = ~clk_i;
        end

        // all driving and sampling happens 1 ns after the rising edge
        task automatic tick();
                @(posedge clk_i);
                #1;
        endtask

        //////////////////////////////////////////////////////////////////////
        // table building with a reference model of the weight rows
        //////////////////////////////////////////////////////////////////////

        // a new row enters at the top, older rows move one row down
        task automatic add_load(input int test, input logic [`CMD_WIDTH-1:0] data);
                vec_t v;
                for (int r = `ARRAY_ROWS - 1; r > 0; r--) begin
                        for (int c = 0; c < `ARRAY_COLS; c++) begin
                                wmodel[r][c] = wmodel[r-1][c];
                        end
                end
                for (int c = 0; c < `ARRAY_COLS; c++) begin
                        wmodel[0][c] = int'($signed(data[c*`WGHT_WIDTH +: `WGHT_WIDTH]));
                end
                v.test    = test;
                v.op      = OP_LOAD_ROW;
                v.data    = data;
                v.exp_res = '0;
                v.ack_dly = 0;
                vec_tbl.push_back(v);
        endtask

        task automatic add_compute(input int test, input logic [`CMD_WIDTH-1:0] data,
                                   input int ack_dly);
                vec_t v;
                int   sum;
                v.exp_res = '0;
                for (int c = 0; c < `ARRAY_COLS; c++) begin
                        sum = 0;
                        for (int r = 0; r < `ARRAY_ROWS; r++) begin
                                sum += int'($signed(data[r*`FEAT_WIDTH +: `FEAT_WIDTH])) *
                                       wmodel[r][c];
                        end
                        v.exp_res[c*PW +: PW] = sum[PW-1:0];
                end
                v.test    = test;
                v.op      = OP_COMPUTE;
                v.data    = data;
                v.ack_dly = ack_dly;
                vec_tbl.push_back(v);
        endtask

        task automatic build_table();
                add_load(2, 32'h04_03_02_01);
                add_load(2, 32'hfc_fd_fe_ff);
                add_load(2, 32'h10_f0_08_f8);
                add_load(2, 32'h7f_80_01_00);
                add_compute(2, 32'h05_fb_03_02, 0);
                for (int i = 0; i < 5; i++) begin
                        add_compute(3, 32'h11_22_f3_04 + i * 32'h0307_0d05, 0);
                end
                // random features and ack delays for back-pressure
                for (int i = 0; i < 8; i++) begin
                        add_compute(4, $random(seed), $random(seed) & 15);
                end
                for (int i = 0; i < 4; i++) begin
                        add_load(5, 32'h80_80_80_80);
                end
                add_compute(5, 32'h80_80_80_80, 1);
                for (int i = 0; i < 2; i++) begin
                        add_load(5, 32'h7f_80_7f_80);
                        add_load(5, 32'h80_7f_80_7f);
                end
                add_compute(5, 32'h7f_80_80_7f, 3);
                add_compute(5, 32'h7f_7f_7f_7f, 0);
                add_load(6, 32'h01_00_00_00);
                add_load(6, 32'h00_01_00_00);
                add_load(6, 32'h00_00_01_00);
                add_load(6, 32'h00_00_00_01);
                add_compute(6, 32'h40_30_20_10, 2);
        endtask

        //////////////////////////////////////////////////////////////////////
        // handshakes
        //////////////////////////////////////////////////////////////////////

        task automatic send_cmd(input op_e op, input logic [`CMD_WIDTH-1:0] data);
                int n;
                cmd_op_i   = op;
                cmd_data_i = data;
                cmd_req_i  = 1'b1;
                n = 0;
                tick();
                while (!cmd_ack_o && n < TMO) begin
                        tick();
                        n++;
                end
                if (!cmd_ack_o) begin
                        $display("timeout: cmd_ack_o never rose for %s", op.name());
                        errors++;
                end
                cmd_req_i = 1'b0;
                n = 0;
                tick();
                while (cmd_ack_o && n < TMO) begin
                        tick();
                        n++;
                end
                if (cmd_ack_o) begin
                        $display("timeout: cmd_ack_o stayed high after req dropped");
                        errors++;
                end
        endtask

        task automatic collect_result();
                logic [RW-1:0] want;
                int            d;
                int            n;
                collecting = 1'b1;
                d = 0;
                if (exp_q.size() == 0) begin
                        $display("a result arrived with no compute pending");
                        errors++;
                end else begin
                        want = exp_q.pop_front();
                        d    = dly_q.pop_front();
                        checks++;
                        assert (res_data_o === want) else begin
                                $display("[FAIL] res_data_o got %h expected %h",
                                         res_data_o, want);
                                errors++;
                        end
                end
                for (n = 0; n < d; n++) begin
                        tick();
                end
                res_ack_i = 1'b1;
                n = 0;
                tick();
                while (res_req_o && n < TMO) begin
                        tick();
                        n++;
                end
                if (res_req_o) begin
                        $display("timeout: res_req_o stayed high after res_ack_i");
                        errors++;
                end
                res_ack_i  = 1'b0;
                results++;
                collecting = 1'b0;
        endtask

        // background result collector
        initial begin
                forever begin
                        tick();
                        if (rst_done && res_req_o) begin
                                collect_result();
                        end
                end
        end

        task automatic drain();
                int n;
                n = 0;
                while ((exp_q.size() != 0 || collecting || res_req_o) && n < TMO) begin
                        tick();
                        n++;
                end
                if (exp_q.size() != 0 || collecting || res_req_o) begin
                        $display("timeout: %0d results still missing", exp_q.size());
                        errors++;
                end
        endtask

        task automatic report_test(input int id, input int err_start);
                if (errors == err_start) begin
                        $display("test %0d %s: ok", id, test_name[id]);
                end else begin
                        $display("test %0d %s: %0d errors", id, test_name[id],
                                 errors - err_start);
                end
        endtask

        //////////////////////////////////////////////////////////////////////
        // main sequence
        //////////////////////////////////////////////////////////////////////

        initial begin
                int cur;
                int err_start;
                rst_n_i    = 1'b0;
                cmd_req_i  = 1'b0;
                cmd_op_i   = OP_LOAD_ROW;
                cmd_data_i = '0;
                res_ack_i  = 1'b0;
                errors     = 0;
                checks     = 0;
                results    = 0;
                rst_done   = 1'b0;
                collecting = 1'b0;
                seed       = 79;
                test_name[1] = "reset idle";
                test_name[2] = "load and compute";
                test_name[3] = "back to back";
                test_name[4] = "back-pressure";
                test_name[5] = "extreme values";
                test_name[6] = "reload weights";
                for (int r = 0; r < `ARRAY_ROWS; r++) begin
                        for (int c = 0; c < `ARRAY_COLS; c++) begin
                                wmodel[r][c] = 0;
                        end
                end
                build_table();

                repeat (3) @(posedge clk_i);
                #1;
                rst_n_i  = 1'b1;
                rst_done = 1'b1;

                err_start = errors;
                assert (cmd_ack_o === 1'b0) else begin
                        $display("[FAIL] cmd_ack_o got %h expected 0", cmd_ack_o);
                        errors++;
                end
                assert (res_req_o === 1'b0) else begin
                        $display("[FAIL] res_req_o got %h expected 0", res_req_o);
                        errors++;
                end
                // idle window, the collector flags any stray result
                repeat (12) tick();
                report_test(1, err_start);

                cur = 0;
                foreach (vec_tbl[i]) begin
                        if (vec_tbl[i].test != cur) begin
                                if (cur != 0) begin
                                        drain();
                                        report_test(cur, err_start);
                                end
                                cur       = vec_tbl[i].test;
                                err_start = errors;
                        end
                        if (vec_tbl[i].op == OP_COMPUTE) begin
                                exp_q.push_back(vec_tbl[i].exp_res);
                                dly_q.push_back(vec_tbl[i].ack_dly);
                        end
                        send_cmd(vec_tbl[i].op, vec_tbl[i].data);
                end
                drain();
                report_test(cur, err_start);

                $display("checks %0d, results %0d, errors %0d", checks, results, errors);
                if (errors == 0) begin
                        $display("TEST RESULT: PASS");
                end else begin
                        $display("TEST RESULT: FAIL");
                end
                $finish;
        end

endmodule

//--- tb.f
+incdir+include
source/array_pkg.sv
source/array_dp_if.sv
source/processing_element.sv
source/pe_grid.sv
source/array_ctrl.sv
source/systolic_array_top.sv
verif/systolic_array_tb.sv

//--- Makefile
TOP := systolic_array_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f tb.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only -Wall --timescale 1ns/100ps +incdir+include \
		--top-module systolic_array_top \
		source/array_pkg.sv source/array_dp_if.sv source/processing_element.sv \
		source/pe_grid.sv source/array_ctrl.sv source/systolic_array_top.sv

clean:
	rm -rf obj_dir sim.log
